// ==== logic/cmd_receiver.sv ====
`timescale 1ns/1ps

module cmd_receiver (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   cmd_req,
    input  vslide_pkg::slide_op_e  cmd_op,
    input  vslide_pkg::vsew_e      cmd_vsew,
    input  vslide_pkg::vlmul_e     cmd_vlmul,
    input  vslide_pkg::vreg_addr_t cmd_vs,
    input  vslide_pkg::vreg_addr_t cmd_vd,
    input  vslide_pkg::vl_t        cmd_vl,
    input  vslide_pkg::scalar_t    cmd_scalar,
    output logic                   cmd_ack,
    slide_cmd_if.receiver          cmd
);
    import vslide_pkg::*;

    typedef enum logic [1:0] {
        RX_IDLE,   // waiting for cmd_req
        RX_WAIT,   // engine running
        RX_ACK     // ack high until req drops
    } rx_state_e;

    rx_state_e state;
    logic      accept;

    // req is low whenever we come back to idle, so this is its rising edge
    assign accept  = (state == RX_IDLE) && cmd_req;
    assign cmd_ack = (state == RX_ACK);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= RX_IDLE;
            cmd.start <= 1'b0;
        end else begin
            cmd.start <= accept;  // fields land on the same edge
            unique case (state)
                RX_IDLE: if (accept) state <= RX_WAIT;
                RX_WAIT: if (cmd.done) state <= RX_ACK;
                RX_ACK:  if (!cmd_req) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    // command fields, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.op     <= cmd_op;
            cmd.vsew   <= cmd_vsew;
            cmd.vlmul  <= cmd_vlmul;
            cmd.vs     <= cmd_vs;
            cmd.vd     <= cmd_vd;
            cmd.vl     <= cmd_vl;
            cmd.scalar <= cmd_scalar;
        end
    end

endmodule

// ==== logic/slide_cmd_if.sv ====
`timescale 1ns/1ps

interface slide_cmd_if;
    import vslide_pkg::*;

    logic       start;   // one cycle, fields valid from here
    slide_op_e  op;
    vsew_e      vsew;
    vlmul_e     vlmul;
    vreg_addr_t vs;
    vreg_addr_t vd;
    vl_t        vl;
    scalar_t    scalar;
    logic       busy;
    logic       done;    // one cycle after the last write

    modport receiver (
        output start, op, vsew, vlmul, vs, vd, vl, scalar,
        input  done
    );

    modport sequencer (
        input  start, op, vsew, vlmul, vs, vd, vl, scalar,
        output busy, done
    );

endinterface

// ==== logic/slide_datapath.sv ====
`timescale 1ns/1ps

module slide_datapath (
    input  logic                   clk,
    input  logic                   reset_n,
    input  vslide_pkg::slide_op_e  op,
    input  vslide_pkg::vsew_e      vsew,
    input  vslide_pkg::vl_t        vl,
    input  vslide_pkg::scalar_t    scalar,
    input  vslide_pkg::chunk_idx_t chunk,
    input  vslide_pkg::vreg_t      src,
    input  vslide_pkg::vreg_t      next,
    output vslide_pkg::vreg_t      result
);
    import vslide_pkg::*;

    logic [1:0]  ew_shift;   // log2 of element size in bytes
    logic [31:0] prev_top;   // upper word of the previous chunk
    vreg_t       down_cand;  // every element moved down by one
    vreg_t       up_cand;    // every element moved up by one
    vreg_t       down_res;
    vreg_t       up_res;

    always_comb begin
        unique case (vsew)
            EW8:     ew_shift = 2'd0;
            EW16:    ew_shift = 2'd1;
            default: ew_shift = 2'd2;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prev_top <= '0;
        end else begin
            prev_top <= src[VLEN-1 -: 32];
        end
    end

    // ********************
    // element shuffle
    // ********************
    // lowest element of next fills the top slot
    assign down_cand = vreg_t'({next, src} >> (8 << ew_shift));
    // top element of the previous chunk fills slot 0
    assign up_cand   = vreg_t'({src, prev_top} >> (32 - (8 << ew_shift)));

    // worked per byte, g is the global index of the owning element
    always_comb begin
        int g;
        int k;
        down_res = src;  // tail keeps the source
        up_res   = src;
        for (int j = 0; j < VLEN / 8; j++) begin
            g = (int'(chunk) << (3 - ew_shift)) + (j >> ew_shift);
            k = j & ((1 << ew_shift) - 1);  // byte inside the element
            if (g + 1 < int'(vl)) begin
                down_res[8*j +: 8] = down_cand[8*j +: 8];
            end else if (g + 1 == int'(vl)) begin
                down_res[8*j +: 8] = scalar[8*k +: 8];
            end
            if (g == 0) begin
                up_res[8*j +: 8] = scalar[8*k +: 8];
            end else if (g < int'(vl)) begin
                up_res[8*j +: 8] = up_cand[8*j +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op == SLIDE1DOWN) begin
            result <= down_res;
        end else begin
            result <= up_res;
        end
    end

endmodule

// ==== logic/slide_sequencer.sv ====
`timescale 1ns/1ps

module slide_sequencer (
    input  logic                   clk,
    input  logic                   reset_n,
    slide_cmd_if.sequencer         cmd,
    vreg_port_if.engine            rf,
    output vslide_pkg::slide_op_e  dp_op,
    output vslide_pkg::vsew_e      dp_vsew,
    output vslide_pkg::vl_t        dp_vl,
    output vslide_pkg::scalar_t    dp_scalar,
    output vslide_pkg::chunk_idx_t dp_chunk,
    output vslide_pkg::vreg_t      dp_src,
    output vslide_pkg::vreg_t      dp_next,
    input  vslide_pkg::vreg_t      dp_result
);
    import vslide_pkg::*;

    seq_state_e state;
    chunk_idx_t chunk;       // chunk being issued
    chunk_idx_t last_chunk;
    chunk_idx_t chunk_q;     // chunk held in the datapath register
    logic       issue;
    logic       issue_q;

    always_comb begin
        unique case (cmd.vlmul)
            LMUL_1:  last_chunk = 3'd0;
            LMUL_2:  last_chunk = 3'd1;
            LMUL_4:  last_chunk = 3'd3;
            default: last_chunk = 3'd7;
        endcase
    end

    // chunk 0 goes out in the start cycle itself
    assign issue = ((state == IDLE) && cmd.start) || (state == RUN);

    // ********************
    // chunk walk
    // ********************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= IDLE;
            chunk   <= '0;
            issue_q <= 1'b0;
        end else begin
            issue_q <= issue;
            unique case (state)
                IDLE: begin
                    if (cmd.start) begin
                        if (last_chunk == '0) begin
                            state <= DRAIN;  // single register group
                        end else begin
                            chunk <= 3'd1;
                            state <= RUN;
                        end
                    end
                end
                RUN: begin
                    if (chunk == last_chunk) begin
                        chunk <= '0;
                        state <= DRAIN;
                    end else begin
                        chunk <= chunk + 3'd1;
                    end
                end
                DRAIN:   state <= DONE;  // last result written here
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        chunk_q <= chunk;
    end

    // ********************
    // register file side
    // ********************
    assign rf.raddr_a = cmd.vs + chunk;
    assign rf.raddr_b = cmd.vs + chunk + 3'd1;  // unused on the last chunk
    assign rf.we      = issue_q;
    assign rf.waddr   = cmd.vd + chunk_q;
    assign rf.wdata   = dp_result;

    // datapath operands
    assign dp_op     = cmd.op;
    assign dp_vsew   = cmd.vsew;
    assign dp_vl     = cmd.vl;
    assign dp_scalar = cmd.scalar;
    assign dp_chunk  = chunk;
    assign dp_src    = rf.rdata_a;
    assign dp_next   = rf.rdata_b;

    // start counts as busy so the host cannot slip in before RUN
    assign cmd.busy = cmd.start || (state != IDLE);
    assign cmd.done = (state == DONE);

endmodule

// ==== logic/vreg_file.sv ====
`timescale 1ns/1ps

module vreg_file (
    input  logic                   clk,
    input  logic                   reset_n,
    vreg_port_if.regfile           rf,
    input  logic                   busy,
    input  logic                   host_req,
    input  logic                   host_we,
    input  vslide_pkg::vreg_addr_t host_addr,
    input  vslide_pkg::vreg_t      host_wdata,
    output vslide_pkg::vreg_t      host_rdata,
    output logic                   host_ack
);
    import vslide_pkg::*;

    typedef enum logic {
        HOST_IDLE,
        HOST_ACK
    } host_state_e;

    host_state_e state;
    vreg_t       regs [NUM_VREGS];
    logic        host_grant;

    // host waits while a slide is in progress
    assign host_grant = (state == HOST_IDLE) && host_req && !busy;
    assign host_ack   = (state == HOST_ACK);

    assign rf.rdata_a = regs[rf.raddr_a];
    assign rf.rdata_b = regs[rf.raddr_b];

    // ********************
    // host handshake
    // ********************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= HOST_IDLE;
        end else begin
            unique case (state)
                HOST_IDLE: if (host_grant) state <= HOST_ACK;
                default:   if (!host_req) state <= HOST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (host_grant && !host_we) begin
            host_rdata <= regs[host_addr];  // stays while ack is high
        end
    end

    // ********************
    // register array
    // ********************
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_VREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we) begin
            regs[rf.waddr] <= rf.wdata;
        end else if (host_grant && host_we) begin
            regs[host_addr] <= host_wdata;
        end
    end

endmodule

// ==== logic/vreg_port_if.sv ====
`timescale 1ns/1ps

interface vreg_port_if;
    import vslide_pkg::*;

    vreg_addr_t raddr_a;  // current chunk
    vreg_addr_t raddr_b;  // following chunk
    vreg_t      rdata_a;
    vreg_t      rdata_b;
    logic       we;
    vreg_addr_t waddr;
    vreg_t      wdata;

    modport engine (
        output raddr_a, raddr_b, we, waddr, wdata,
        input  rdata_a, rdata_b
    );

    modport regfile (
        input  raddr_a, raddr_b, we, waddr, wdata,
        output rdata_a, rdata_b
    );

endinterface

// ==== logic/vslide_pkg.sv ====
package vslide_pkg;

    // ********************
    // sizes
    // ********************
    localparam int VLEN      = 64;  // bits per vector register
    localparam int NUM_VREGS = 8;

    // ********************
    // vector types
    // ********************
    typedef logic [VLEN-1:0] vreg_t;       // one register, one chunk
    typedef logic [2:0]      vreg_addr_t;  // register number
    typedef logic [5:0]      vl_t;         // element count, up to 32
    typedef logic [2:0]      chunk_idx_t;  // chunk inside a group
    typedef logic [31:0]     scalar_t;

    // ********************
    // command encodings
    // ********************
    typedef enum logic {
        SLIDE1UP,
        SLIDE1DOWN
    } slide_op_e;

    typedef enum logic [1:0] {
        EW8,
        EW16,
        EW32
    } vsew_e;

    typedef enum logic [1:0] {
        LMUL_1,
        LMUL_2,
        LMUL_4,
        LMUL_8
    } vlmul_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } seq_state_e;

endpackage

// ==== logic/vslide_top.sv ====
`timescale 1ns/1ps

module vslide_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   cmd_req,
    input  vslide_pkg::slide_op_e  cmd_op,
    input  vslide_pkg::vsew_e      cmd_vsew,
    input  vslide_pkg::vlmul_e     cmd_vlmul,
    input  vslide_pkg::vreg_addr_t cmd_vs,
    input  vslide_pkg::vreg_addr_t cmd_vd,
    input  vslide_pkg::vl_t        cmd_vl,
    input  vslide_pkg::scalar_t    cmd_scalar,
    output logic                   cmd_ack,
    input  logic                   host_req,
    input  logic                   host_we,
    input  vslide_pkg::vreg_addr_t host_addr,
    input  vslide_pkg::vreg_t      host_wdata,
    output vslide_pkg::vreg_t      host_rdata,
    output logic                   host_ack
);
    import vslide_pkg::*;

    slide_op_e  dp_op;
    vsew_e      dp_vsew;
    vl_t        dp_vl;
    scalar_t    dp_scalar;
    chunk_idx_t dp_chunk;
    vreg_t      dp_src;
    vreg_t      dp_next;
    vreg_t      dp_result;

    slide_cmd_if cmd_if ();
    vreg_port_if rf_if ();

    // ********************
    // command input
    // ********************
    cmd_receiver u_cmd_receiver (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd_req    (cmd_req),
        .cmd_op     (cmd_op),
        .cmd_vsew   (cmd_vsew),
        .cmd_vlmul  (cmd_vlmul),
        .cmd_vs     (cmd_vs),
        .cmd_vd     (cmd_vd),
        .cmd_vl     (cmd_vl),
        .cmd_scalar (cmd_scalar),
        .cmd_ack    (cmd_ack),
        .cmd        (cmd_if.receiver)
    );

    // ********************
    // slide engine
    // ********************
    slide_sequencer u_slide_sequencer (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd       (cmd_if.sequencer),
        .rf        (rf_if.engine),
        .dp_op     (dp_op),
        .dp_vsew   (dp_vsew),
        .dp_vl     (dp_vl),
        .dp_scalar (dp_scalar),
        .dp_chunk  (dp_chunk),
        .dp_src    (dp_src),
        .dp_next   (dp_next),
        .dp_result (dp_result)
    );

    slide_datapath u_slide_datapath (
        .clk     (clk),
        .reset_n (reset_n),
        .op      (dp_op),
        .vsew    (dp_vsew),
        .vl      (dp_vl),
        .scalar  (dp_scalar),
        .chunk   (dp_chunk),
        .src     (dp_src),
        .next    (dp_next),
        .result  (dp_result)
    );

    // registers and host port
    vreg_file u_vreg_file (
        .clk        (clk),
        .reset_n    (reset_n),
        .rf         (rf_if.regfile),
        .busy       (cmd_if.busy),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .host_ack   (host_ack)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --top-module tb_vslide -f sources.f -o sim_vslide; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_vslide > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q '>>> FAIL' "$log"; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q '>>> PASS' "$log"; then
    echo "no pass message found in $log"
    exit 1
fi
exit 0

// ==== sources.f ====
+incdir+test
logic/vslide_pkg.sv
logic/slide_cmd_if.sv
logic/vreg_port_if.sv
logic/cmd_receiver.sv
logic/slide_sequencer.sv
logic/slide_datapath.sv
logic/vreg_file.sv
logic/vslide_top.sv
test/tb_vslide.sv

// ==== test/tb_vslide_ref.svh ====
`ifndef TB_VSLIDE_REF_SVH
`define TB_VSLIDE_REF_SVH

// register group as one flat image, register n of the group at bits n*VLEN
typedef logic [NUM_VREGS*VLEN-1:0] group_img_t;

function automatic int elem_bits(input vsew_e vsew);
    case (vsew)
        EW8:     return 8;
        EW16:    return 16;
        default: return 32;
    endcase
endfunction

// plain 32-bit lcg, the upper bits are the useful ones
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

// expected destination group for slide1up or slide1down
function automatic group_img_t slide_ref(
    input group_img_t src,
    input slide_op_e  op,
    input vsew_e      vsew,
    input vlmul_e     vlmul,
    input vl_t        vl,
    input scalar_t    scalar
);
    group_img_t  res;
    logic [31:0] mask;
    logic [31:0] elem;
    int          w;
    int          nelem;
    w     = elem_bits(vsew);
    nelem = (VLEN << int'(vlmul)) / w;
    mask  = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
    res   = src;  // tail elements keep the source
    for (int g = 0; g < nelem && g < int'(vl); g++) begin
        if (op == SLIDE1DOWN) begin
            elem = (g == int'(vl) - 1) ? scalar : 32'(src >> ((g + 1) * w));
        end else begin
            elem = (g == 0) ? scalar : 32'(src >> ((g - 1) * w));
        end
        res = res & ~(group_img_t'(mask) << (g * w));
        res = res | (group_img_t'(elem & mask) << (g * w));
    end
    return res;
endfunction

`endif

// ==== test/tb_vslide.sv ====
`timescale 1ns/1ps

module tb_vslide;
    import vslide_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic       clk;
    logic       reset_n;
    logic       cmd_req;
    slide_op_e  cmd_op;
    vsew_e      cmd_vsew;
    vlmul_e     cmd_vlmul;
    vreg_addr_t cmd_vs;
    vreg_addr_t cmd_vd;
    vl_t        cmd_vl;
    scalar_t    cmd_scalar;
    logic       cmd_ack;
    logic       host_req;
    logic       host_we;
    vreg_addr_t host_addr;
    vreg_t      host_wdata;
    vreg_t      host_rdata;
    logic       host_ack;

    logic [31:0] rng;
    vreg_t       model [NUM_VREGS];  // expected register contents

    `include "tb_vslide_ref.svh"

    vslide_top u_vslide_top (.*);

    always #2 clk = ~clk;  // 4 ns period

    // ********************
    // helpers
    // ********************
    task automatic tick();
        @(posedge clk);
        #1;  // drive and sample away from the edge
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input vreg_t expected, input vreg_t actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] next_rand();
        rng = lcg_next(rng);
        return rng;
    endfunction

    function automatic int pick(input int n);
        return int'(next_rand() >> 16) % n;  // 0 .. n-1
    endfunction

    task automatic wait_ack(input bit on_cmd, input logic level, input string what);
        int cycles;
        cycles = 0;
        while ((on_cmd ? cmd_ack : host_ack) !== level) begin
            tick();
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_run($sformatf("timeout while waiting for %s", what));
            end
        end
    endtask

    // ********************
    // bus handshakes
    // ********************
    task automatic host_write(input vreg_addr_t addr, input vreg_t data);
        host_req   = 1'b1;
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        wait_ack(1'b0, 1'b1, "host_ack to rise on a write");
        host_req = 1'b0;
        model[addr] = data;
        wait_ack(1'b0, 1'b0, "host_ack to fall on a write");
    endtask

    task automatic host_read(input vreg_addr_t addr, output vreg_t data);
        host_req  = 1'b1;
        host_we   = 1'b0;
        host_addr = addr;
        wait_ack(1'b0, 1'b1, "host_ack to rise on a read");
        data     = host_rdata;
        host_req = 1'b0;
        wait_ack(1'b0, 1'b0, "host_ack to fall on a read");
    endtask

    // compare all eight registers against the model
    task automatic verify_all(input string name);
        vreg_t data;
        for (int i = 0; i < NUM_VREGS; i++) begin
            host_read(vreg_addr_t'(i), data);
            check_value($sformatf("%s v%0d", name, i), model[vreg_addr_t'(i)], data);
        end
    endtask

    // model is updated before cmd_req rises
    task automatic issue_slide(input slide_op_e op, input vsew_e vsew, input vlmul_e vlmul,
                               input vreg_addr_t vs, input vreg_addr_t vd, input vl_t vl,
                               input scalar_t scalar);
        group_img_t src_img;
        group_img_t exp_img;
        int         nregs;
        nregs   = 1 << int'(vlmul);
        src_img = '0;
        for (int i = 0; i < nregs; i++) begin
            src_img = src_img | (group_img_t'(model[vreg_addr_t'(int'(vs) + i)]) << (i * VLEN));
        end
        exp_img = slide_ref(src_img, op, vsew, vlmul, vl, scalar);
        for (int i = 0; i < nregs; i++) begin
            model[vreg_addr_t'(int'(vd) + i)] = vreg_t'(exp_img >> (i * VLEN));
        end
        cmd_op     = op;
        cmd_vsew   = vsew;
        cmd_vlmul  = vlmul;
        cmd_vs     = vs;
        cmd_vd     = vd;
        cmd_vl     = vl;
        cmd_scalar = scalar;
        cmd_req    = 1'b1;
    endtask

    task automatic run_slide(input string name, input slide_op_e op, input vsew_e vsew,
                             input vlmul_e vlmul, input vreg_addr_t vs, input vreg_addr_t vd,
                             input vl_t vl, input scalar_t scalar);
        issue_slide(op, vsew, vlmul, vs, vd, vl, scalar);
        wait_ack(1'b1, 1'b1, "cmd_ack to rise");
        cmd_req = 1'b0;
        wait_ack(1'b1, 1'b0, "cmd_ack to fall");
        verify_all(name);
    endtask

    // host read raised one cycle into a slide must wait for the slide
    task automatic slide_under_host_read(input string name);
        vreg_t data;
        bit    cmd_seen;
        int    cycles;
        issue_slide(SLIDE1DOWN, EW8, LMUL_4, 3'd4, 3'd0, 6'd20, next_rand());
        tick();
        host_req  = 1'b1;
        host_we   = 1'b0;
        host_addr = 3'd0;
        cmd_seen  = 1'b0;
        cycles    = 0;
        while (host_ack !== 1'b1) begin
            tick();
            cycles++;
            if (cmd_ack === 1'b1) cmd_seen = 1'b1;
            if (cycles > TIMEOUT_CYCLES) fail_run("timeout while a host read waited on a slide");
        end
        if (!cmd_seen) fail_run("host_ack rose before the slide finished");
        data = host_rdata;
        check_value(name, model[3'd0], data);
        host_req = 1'b0;
        cmd_req  = 1'b0;
        wait_ack(1'b0, 1'b0, "host_ack to fall after the blocked read");
        wait_ack(1'b1, 1'b0, "cmd_ack to fall after the blocked read");
        verify_all(name);
    endtask

    task automatic random_command(input int idx);
        vsew_e  vsew;
        vlmul_e vlmul;
        int     nregs;
        int     ngroups;
        int     vlmax;
        int     src_grp;
        int     dst_grp;
        host_write(vreg_addr_t'(pick(NUM_VREGS)), {next_rand(), next_rand()});
        vsew    = vsew_e'(2'(pick(3)));
        vlmul   = vlmul_e'(2'(pick(3)));  // lmul 8 leaves no separate destination
        nregs   = 1 << int'(vlmul);
        ngroups = NUM_VREGS / nregs;
        vlmax   = (VLEN * nregs) / elem_bits(vsew);
        src_grp = pick(ngroups);
        dst_grp = (src_grp + 1 + pick(ngroups - 1)) % ngroups;
        run_slide($sformatf("random_%0d", idx), slide_op_e'(1'(pick(2))), vsew, vlmul,
                  vreg_addr_t'(src_grp * nregs), vreg_addr_t'(dst_grp * nregs),
                  vl_t'(1 + pick(vlmax)), next_rand());
    endtask

    // ********************
    // test sequence
    // ********************
    initial begin
        vsew_e ew;
        int    vmax;
        clk        = 1'b0;
        reset_n    = 1'b0;
        cmd_req    = 1'b0;
        cmd_op     = SLIDE1UP;
        cmd_vsew   = EW8;
        cmd_vlmul  = LMUL_1;
        cmd_vs     = '0;
        cmd_vd     = '0;
        cmd_vl     = '0;
        cmd_scalar = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        rng        = 32'd66185;
        for (int i = 0; i < NUM_VREGS; i++) model[i] = '0;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;
        tick();

        verify_all("reset");
        for (int i = 0; i < NUM_VREGS; i++) begin
            host_write(vreg_addr_t'(i), {next_rand(), next_rand()});
        end
        verify_all("host_rw");

        // single register at full vl
        run_slide("down_ew8", SLIDE1DOWN, EW8, LMUL_1, 3'd2, 3'd5, 6'd8, next_rand());
        run_slide("down_ew16", SLIDE1DOWN, EW16, LMUL_1, 3'd2, 3'd5, 6'd4, next_rand());
        run_slide("down_ew32", SLIDE1DOWN, EW32, LMUL_1, 3'd2, 3'd5, 6'd2, next_rand());

        // chunk boundaries
        run_slide("up_lmul2", SLIDE1UP, EW8, LMUL_2, 3'd4, 3'd6, 6'd16, next_rand());
        run_slide("up_lmul4", SLIDE1UP, EW16, LMUL_4, 3'd0, 3'd4, 6'd16, next_rand());
        run_slide("up_lmul8", SLIDE1UP, EW32, LMUL_8, 3'd0, 3'd0, 6'd16, next_rand());  // in place

        for (int n = 0; n < 6; n++) begin
            ew   = vsew_e'(2'(pick(3)));
            vmax = (2 * VLEN) / elem_bits(ew);
            run_slide($sformatf("partial_%0d", n), slide_op_e'(1'(n % 2)), ew, LMUL_2,
                      3'd2, 3'd6, vl_t'(1 + pick(vmax - 1)), next_rand());
        end

        slide_under_host_read("backpressure");

        for (int n = 0; n < 30; n++) random_command(n);

        $display(">>> PASS");
        $finish;
    end

endmodule
